// File: rtl/psram_pkg.sv
package psram_pkg;

    // ##############################
    // bus geometry
    // ##############################
    localparam int addr_width     = 24;
    localparam int word_bytes     = 4;
    localparam int mem_depth_bits = 16;  // device keeps only these address bits

    // ##############################
    // qspi commands
    // ##############################
    localparam logic [7:0] cmd_write = 8'h38;
    localparam logic [7:0] cmd_read  = 8'heb;  // quad read

    // ##############################
    // frame phase lengths in sck cycles
    // ##############################
    localparam int cmd_cycles  = 8;  // one bit per cycle on dio[0]
    localparam int addr_cycles = 6;  // address nibbles, msb first
    localparam int wait_cycles = 6;  // read turnaround
    localparam int data_cycles = 8;  // nibbles per word

    // host request, byte 0 of wdata lands at addr
    typedef struct packed {
        logic                    write;
        logic [addr_width-1:0]   addr;
        logic [8*word_bytes-1:0] wdata;
    } host_req_t;

    // host response, same byte order as wdata
    typedef struct packed {
        logic [8*word_bytes-1:0] rdata;
    } host_rsp_t;

    // one frame as handed to the frame engine
    typedef struct packed {
        logic [7:0]              cmd;
        logic [addr_width-1:0]   addr;
        logic [8*word_bytes-1:0] wdata;
        logic                    is_read;
    } qspi_frame_t;

endpackage

// File: rtl/qspi_frame_engine.sv
module qspi_frame_engine
    import psram_pkg::*;
(
    input  logic        sck,
    input  logic        reset,
    input  logic        start,
    input  qspi_frame_t frame,
    output logic        done,
    output logic [31:0] rdata,
    output logic        ce_n,
    inout  logic [3:0]  dio
);

    typedef enum logic [2:0] {
        st_idle,
        st_cmd,
        st_addr,
        st_wait,
        st_wdata,
        st_rdata,
        st_gap
    } eng_state_t;

    eng_state_t                           state;
    logic [4:0]                           cnt;      // frame cycle on the bus
    logic [8+addr_width+8*word_bytes-1:0] shreg;    // cmd, addr, data stream
    logic                                 is_read;
    logic                                 drive;
    logic [3:0]                           out_nib;

    // byte 0 goes out first, so reverse the byte order of the word
    function automatic logic [8*word_bytes-1:0] byte_stream(
        input logic [8*word_bytes-1:0] w
    );
        logic [8*word_bytes-1:0] s;
        for (int i = 0; i < word_bytes; i++) begin
            s[8*(word_bytes-1-i) +: 8] = w[8*i +: 8];
        end
        return s;
    endfunction

    // ##############################
    // bus drive
    // ##############################
    assign drive   = (state == st_cmd) || (state == st_addr) || (state == st_wdata);
    assign out_nib = (state == st_cmd) ? {3'b000, shreg[$left(shreg)]}
                                       : shreg[$left(shreg) -: 4];
    assign dio     = drive ? out_nib : 4'bz;

    assign rdata = byte_stream(shreg[8*word_bytes-1:0]);  // captured nibbles

    // ##############################
    // frame sequencer
    // ##############################
    always_ff @(posedge sck or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            cnt   <= '0;
            ce_n  <= 1'b1;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (start) begin
                        ce_n  <= 1'b0;
                        state <= st_cmd;
                    end
                end
                st_cmd: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'(cmd_cycles - 1)) state <= st_addr;
                end
                st_addr: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'(cmd_cycles + addr_cycles - 1)) begin
                        state <= is_read ? st_wait : st_wdata;
                    end
                end
                st_wait: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'(cmd_cycles + addr_cycles + wait_cycles - 1)) begin
                        state <= st_rdata;
                    end
                end
                st_wdata: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'(cmd_cycles + addr_cycles + data_cycles - 1)) begin
                        ce_n  <= 1'b1;
                        done  <= 1'b1;
                        state <= st_gap;
                    end
                end
                st_rdata: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'(cmd_cycles + addr_cycles + wait_cycles + data_cycles - 1)) begin
                        ce_n  <= 1'b1;
                        done  <= 1'b1;
                        state <= st_gap;
                    end
                end
                default: state <= st_idle;  // gap keeps ce_n high one more cycle
            endcase
        end
    end

    // shift register, loaded on start
    always_ff @(posedge sck) begin
        case (state)
            st_idle: begin
                if (start) begin
                    shreg   <= {frame.cmd, frame.addr, byte_stream(frame.wdata)};
                    is_read <= frame.is_read;
                end
            end
            st_cmd:             shreg <= {shreg[$left(shreg)-1:0], 1'b0};
            st_addr, st_wdata:  shreg <= {shreg[$left(shreg)-4:0], 4'b0000};
            st_rdata:           shreg <= {shreg[$left(shreg)-4:0], dio};  // capture
            default:            shreg <= shreg;
        endcase
    end

endmodule

// File: rtl/psram_ctrl.sv
module psram_ctrl
    import psram_pkg::*;
(
    input  logic       sck,
    input  logic       reset,
    input  logic       req,
    input  host_req_t  req_data,
    output logic       ack,
    output host_rsp_t  rsp,
    output logic       ce_n,
    inout  logic [3:0] dio
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_hold_ack,
        st_release
    } ctrl_state_t;

    ctrl_state_t             state;
    host_req_t               req_q;   // latched request
    qspi_frame_t             frame;
    logic                    start;
    logic                    done;
    logic [8*word_bytes-1:0] rdata;

    // frame built from the latched request
    always_comb begin
        frame.cmd     = req_q.write ? cmd_write : cmd_read;
        frame.addr    = req_q.addr;
        frame.wdata   = req_q.wdata;
        frame.is_read = !req_q.write;
    end

    // ##############################
    // four-phase handshake
    // ##############################
    always_ff @(posedge sck or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            start <= 1'b0;
            ack   <= 1'b0;
            rsp   <= '0;
        end else begin
            start <= 1'b0;
            case (state)
                st_idle: begin
                    if (req) begin
                        start <= 1'b1;  // engine is idle here
                        state <= st_run;
                    end
                end
                st_run: begin
                    if (done) begin
                        if (!req_q.write) rsp.rdata <= rdata;
                        ack   <= 1'b1;
                        state <= st_hold_ack;
                    end
                end
                st_hold_ack: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_release;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge sck) begin
        if (state == st_idle && req) req_q <= req_data;
    end

    qspi_frame_engine i_qspi_frame_engine (
        .sck   (sck),
        .reset (reset),
        .start (start),
        .frame (frame),
        .done  (done),
        .rdata (rdata),
        .ce_n  (ce_n),
        .dio   (dio)
    );

endmodule

// File: rtl/psram_device.sv
module psram_device
    import psram_pkg::*;
(
    input  logic       sck,
    input  logic       ce_n,
    inout  logic [3:0] dio
);

    typedef enum logic [2:0] {
        st_cmd,
        st_addr,
        st_wait,
        st_wdata,
        st_rdata,
        st_ignore
    } dev_state_t;

    dev_state_t              state;
    dev_state_t              next_state;
    logic [5:0]              count;     // cycles since ce_n fell
    logic [7:0]              cmd;
    logic [addr_width-1:0]   addr;
    logic [3:0]              wbuf;      // high nibble of a write byte
    logic [3:0]              rd_nib;
    logic [mem_depth_bits-1:0] idx;
    logic [7:0]              mem [2**mem_depth_bits];

    assign idx    = addr[mem_depth_bits-1:0];  // upper bits alias
    assign rd_nib = count[0] ? mem[idx][3:0] : mem[idx][7:4];
    assign dio    = (state == st_rdata) ? rd_nib : 4'bz;

    // ##############################
    // frame state, reset by ce_n
    // ##############################
    always_ff @(posedge sck or posedge ce_n) begin
        if (ce_n) begin
            state <= st_cmd;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_cmd: begin
                if (count == 6'(cmd_cycles - 1)) next_state = st_addr;
            end
            st_addr: begin
                if (count == 6'(cmd_cycles + addr_cycles - 1)) begin
                    if (cmd == cmd_write) begin
                        next_state = st_wdata;
                    end else if (cmd == cmd_read) begin
                        next_state = st_wait;
                    end else begin
                        next_state = st_ignore;  // rest of frame dropped
                    end
                end
            end
            st_wait: begin
                if (count == 6'(cmd_cycles + addr_cycles + wait_cycles - 1)) begin
                    next_state = st_rdata;
                end
            end
            default: next_state = state;
        endcase
    end

    always_ff @(posedge sck or posedge ce_n) begin
        if (ce_n) begin
            count <= '0;
        end else begin
            count <= count + 6'd1;
        end
    end

    // command bits on dio[0], msb first
    always_ff @(posedge sck or posedge ce_n) begin
        if (ce_n) begin
            cmd <= '0;
        end else if (state == st_cmd) begin
            cmd <= {cmd[6:0], dio[0]};
        end
    end

    always_ff @(posedge sck or posedge ce_n) begin
        if (ce_n) begin
            addr <= '0;
        end else if (state == st_addr) begin
            addr <= {addr[addr_width-5:0], dio};
        end else if ((state == st_wdata || state == st_rdata) && count[0]) begin
            addr <= addr + 1'b1;  // next byte
        end
    end

    // ##############################
    // byte array
    // ##############################
    always_ff @(posedge sck) begin
        if (state == st_wdata && !count[0]) wbuf <= dio;
    end

    always_ff @(posedge sck) begin
        if (state == st_wdata && count[0]) mem[idx] <= {wbuf, dio};
    end

endmodule

// File: rtl/psram_subsystem.sv
module psram_subsystem
    import psram_pkg::*;
(
    input  logic      sck,
    input  logic      reset,
    input  logic      req,
    input  host_req_t req_data,
    output logic      ack,
    output host_rsp_t rsp
);

    // ##############################
    // shared qspi bus
    // ##############################
    wire  [3:0] dio;   // tri-state, engine or device
    logic       ce_n;

    psram_ctrl i_psram_ctrl (
        .sck      (sck),
        .reset    (reset),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp),
        .ce_n     (ce_n),
        .dio      (dio)
    );

    // behavioral memory at the far end
    psram_device i_psram_device (
        .sck  (sck),
        .ce_n (ce_n),
        .dio  (dio)
    );

endmodule

// File: verification/clock_gen.sv
module clock_gen (
    output logic sck,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles = 10;

    initial begin
        sck = 1'b0;
        forever #2 sck = ~sck;  // 4 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge sck);
        #1 reset = 1'b0;  // released off the edge
    end

endmodule

// File: verification/psram_tb.sv
module psram_tb
    import psram_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int mem_bytes   = 2**mem_depth_bits;
    localparam int ack_timeout = 100;  // well over one frame in cycles
    localparam int rel_timeout = 8;
    localparam int num_random  = 200;

    logic      sck;
    logic      reset;
    logic      req;
    host_req_t req_data;
    logic      ack;
    host_rsp_t rsp;

    // reference memory
    logic [7:0]            model_mem   [mem_bytes];
    logic [addr_width-1:0] written_q   [$];

    int seed;
    int test_errors;
    int total_errors;
    int tests_passed;
    int tests_failed;

    clock_gen i_clock_gen (
        .sck   (sck),
        .reset (reset)
    );

    psram_subsystem i_psram_subsystem (
        .sck      (sck),
        .reset    (reset),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp)
    );

    // ##############################
    // reference model
    // ##############################
    function automatic int byte_index(input logic [addr_width-1:0] addr, input int offset);
        logic [addr_width-1:0] a;
        a = addr + addr_width'(offset);
        return int'(a) % mem_bytes;  // device aliases above mem_depth_bits
    endfunction

    function automatic void model_write(input logic [addr_width-1:0] addr,
                                        input logic [31:0] wdata);
        for (int i = 0; i < word_bytes; i++) begin
            model_mem[byte_index(addr, i)] = wdata[8*i +: 8];
        end
    endfunction

    function automatic host_rsp_t model_read(input logic [addr_width-1:0] addr);
        host_rsp_t r;
        for (int i = 0; i < word_bytes; i++) begin
            r.rdata[8*i +: 8] = model_mem[byte_index(addr, i)];
        end
        return r;
    endfunction

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // ##############################
    // checks and waits
    // ##############################
    task automatic next_cycle();
        @(posedge sck);
        #1;
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: %s", what);
        $display("tests failed");
        $finish;
    endtask

    task automatic compare_rsp(input string name, input host_rsp_t expected,
                               input host_rsp_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected.rdata, actual.rdata);
            test_errors++;
        end
    endtask

    task automatic compare_ack(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected ack %b, actual ack %b", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic wait_ack(input logic level, input int limit, input string name);
        int n;
        n = 0;
        while (ack !== level && n < limit) begin
            next_cycle();
            n++;
        end
        if (ack !== level) begin
            timeout_fail($sformatf("ack never went %b within %0d cycles in test %s",
                                   level, limit, name));
        end
    endtask

    // one four-phase transaction with req held hold cycles past ack
    task automatic run_txn(
        input  string                 name,
        input  logic                  wr,
        input  logic [addr_width-1:0] addr,
        input  logic [31:0]           wdata,
        input  int                    hold,
        output host_rsp_t             rd
    );
        compare_ack(name, 1'b0, ack);  // ack seen low before req
        req            = 1'b1;
        req_data.write = wr;
        req_data.addr  = addr;
        req_data.wdata = wdata;
        wait_ack(1'b1, ack_timeout, name);
        rd = rsp;
        for (int i = 0; i < hold; i++) begin
            next_cycle();
            compare_ack(name, 1'b1, ack);  // must stay up while req high
        end
        req = 1'b0;
        wait_ack(1'b0, rel_timeout, name);
    endtask

    task automatic write_word(input string name, input logic [addr_width-1:0] addr,
                              input logic [31:0] wdata, input int hold);
        host_rsp_t unused;
        run_txn(name, 1'b1, addr, wdata, hold, unused);
        model_write(addr, wdata);
        written_q.push_back(addr);
    endtask

    task automatic check_read(input string name, input logic [addr_width-1:0] addr,
                              input int hold);
        host_rsp_t rd;
        run_txn(name, 1'b0, addr, '0, hold, rd);
        compare_rsp(name, model_read(addr), rd);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // ##############################
    // test sequence
    // ##############################
    initial begin
        logic [31:0]           r;
        logic [31:0]           w1;
        logic [31:0]           w2;
        logic [addr_width-1:0] a;
        host_rsp_t             exp;
        host_rsp_t             rd;
        int                    n;
        int                    k;

        req          = 1'b0;
        req_data     = '0;
        seed         = 69967;
        test_errors  = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;

        // reset state
        next_cycle();
        n = 0;
        while (reset === 1'b1 && n < 20) begin
            compare_ack("reset_state", 1'b0, ack);
            compare_rsp("reset_state", '0, rsp);
            next_cycle();
            n++;
        end
        if (reset === 1'b1) timeout_fail("reset never deasserted");
        for (int i = 0; i < 3; i++) begin
            compare_ack("reset_state", 1'b0, ack);
            compare_rsp("reset_state", '0, rsp);
            next_cycle();
        end
        finish_test("reset_state");

        // aligned write then read
        r = next_random();
        a = {r[addr_width-1:2], 2'b00};
        w1 = next_random();
        write_word("write_read", a, w1, 0);
        exp.rdata = w1;
        run_txn("write_read", 1'b0, a, '0, 0, rd);
        compare_rsp("write_read", exp, rd);
        finish_test("write_read");

        // random mix over a small window with aliased upper bits
        for (int i = 0; i < num_random; i++) begin
            r = next_random();
            if (written_q.size() == 0 || r[0]) begin
                a  = {r[23:16], 8'h00, r[15:8]};
                w1 = next_random();
                write_word("random_mix", a, w1, int'(r[5:4]));
            end else begin
                k = int'(next_random() % written_q.size());
                check_read("random_mix", written_q[k], int'(r[5:4]));
            end
        end
        finish_test("random_mix");

        // overlapping unaligned words
        r  = next_random();
        a  = r[addr_width-1:0] | 24'h1;
        w1 = next_random();
        w2 = next_random();
        write_word("overlap", a, w1, 0);
        write_word("overlap", a + 24'd2, w2, 0);
        exp.rdata = {w2[15:0], w1[15:0]};  // low half from w1 and high half from w2
        run_txn("overlap", 1'b0, a, '0, 1, rd);
        compare_rsp("overlap", exp, rd);
        finish_test("overlap");

        // aliasing above mem_depth_bits
        r  = next_random();
        w1 = next_random();
        a  = {r[23:16] | 8'h01, r[15:0]};
        write_word("aliasing", a, w1, 0);
        exp.rdata = w1;
        run_txn("aliasing", 1'b0, {8'h00, r[15:0]}, '0, 0, rd);
        compare_rsp("aliasing", exp, rd);
        run_txn("aliasing", 1'b0, {8'h80, r[15:0]}, '0, 2, rd);
        compare_rsp("aliasing", exp, rd);
        finish_test("aliasing");

        // handshake order with long req holds
        for (int i = 0; i < 8; i++) begin
            r  = next_random();
            a  = {r[23:2], 2'b00};
            w1 = next_random();
            write_word("handshake", a, w1, i);
            check_read("handshake", a, 7 - i);
        end
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            compare_ack("handshake", 1'b0, ack);  // no ack without req
        end
        finish_test("handshake");

        $display("summary: %0d passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: project.f
rtl/psram_pkg.sv
rtl/qspi_frame_engine.sv
rtl/psram_ctrl.sv
rtl/psram_device.sv
rtl/psram_subsystem.sv
verification/clock_gen.sv
verification/psram_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := psram_tb
FILELIST   := project.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := all tests passed
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
